// ==== src/apb_pkg.sv ====
`default_nettype none

package apb_pkg;

	////////////////////////////////////////
	// Bus widths

	// Byte addressed, one word per transfer
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	// One strobe per data byte
	localparam int STRB_WIDTH = DATA_WIDTH / 8;

	////////////////////////////////////////
	// APB channel structs

	// Requester to completer, all fields sampled in the access phase
	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [ADDR_WIDTH-1:0] paddr;
		logic [DATA_WIDTH-1:0] pwdata;
		logic [STRB_WIDTH-1:0] pstrb;
		// Carried along, peripherals here ignore it
		logic [2:0]            pprot;
	} apb_req_t;

	// Completer to requester, prdata and pslverr only meaningful with pready
	typedef struct packed {
		logic                  pready;
		logic                  pslverr;
		logic [DATA_WIDTH-1:0] prdata;
	} apb_rsp_t;

	////////////////////////////////////////
	// CRC-32 constants

	// Reflected form of 0x04C11DB7, data shifted in LSB first
	localparam logic [31:0] CRC_POLY   = 32'hEDB8_8320;
	localparam logic [31:0] CRC_INIT   = 32'hFFFF_FFFF;
	localparam logic [31:0] CRC_XOROUT = 32'hFFFF_FFFF;

	// Register offsets within the CRC block
	localparam logic [ADDR_WIDTH-1:0] CRC_REG_DATA   = 32'h0000_0000;
	localparam logic [ADDR_WIDTH-1:0] CRC_REG_RESULT = 32'h0000_0004;
	localparam logic [ADDR_WIDTH-1:0] CRC_REG_INIT   = 32'h0000_0008;

endpackage

`default_nettype wire

// ==== src/apb_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

// One completer port fanned out to NUM_PORTS equal address blocks
// Purely combinational, no added latency on any path
module apb_bridge #(
	// Start of the window, must be aligned to NUM_PORTS blocks
	parameter logic [apb_pkg::ADDR_WIDTH-1:0] BASE_ADDR      = 32'h4000_0000,
	// Bytes per peripheral, power of two
	parameter logic [apb_pkg::ADDR_WIDTH-1:0] BLOCK_SIZE     = 32'h0000_0800,
	parameter int                             NUM_PORTS      = 2,
	// Terminate out-of-window accesses with an error
	parameter bit                             ERR_ON_INVALID = 1'b1
) (
	input  apb_pkg::apb_req_t upstream_req,
	output apb_pkg::apb_rsp_t upstream_rsp,
	output apb_pkg::apb_req_t downstream_req [NUM_PORTS-1:0],
	input  apb_pkg::apb_rsp_t downstream_rsp [NUM_PORTS-1:0]
);

	import apb_pkg::*;

	////////////////////////////////////////
	// Address split

	// paddr = {range tag, device index, offset}
	localparam int BLOCK_BITS  = $clog2(BLOCK_SIZE);
	localparam int DEVICE_BITS = ADDR_WIDTH - BLOCK_BITS;
	// Keep at least one index bit so a single port still elaborates
	localparam int INDEX_BITS  = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

	localparam logic [DEVICE_BITS-1:0] BASE_BLOCK = BASE_ADDR[ADDR_WIDTH-1:BLOCK_BITS];

	// Strips the block number, peripherals only see their own offset
	localparam logic [ADDR_WIDTH-1:0] OFFSET_MASK = BLOCK_SIZE - 1'b1;

	logic [DEVICE_BITS-1:0] block_addr;
	logic [INDEX_BITS-1:0]  devid;
	logic                   range_match;
	logic                   port_hit;

	assign block_addr = upstream_req.paddr[ADDR_WIDTH-1:BLOCK_BITS];
	assign devid      = block_addr[INDEX_BITS-1:0];

	// Range tag is whatever sits above the device index
	if (DEVICE_BITS > INDEX_BITS) begin : g_range_tag
		assign range_match = (block_addr[DEVICE_BITS-1:INDEX_BITS] ==
			BASE_BLOCK[DEVICE_BITS-1:INDEX_BITS]);
	end else begin : g_no_range_tag
		// Index covers the whole upper address, everything decodes
		assign range_match = 1'b1;
	end

	// Index past the last port counts as a miss when NUM_PORTS is not a power of two
	assign port_hit = range_match && (int'(devid) < NUM_PORTS);

	////////////////////////////////////////
	// Request fan-out

	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
		always_comb begin
			// Shared fields go to every port unchanged
			downstream_req[g] = upstream_req;

			// Block-relative address
			downstream_req[g].paddr = upstream_req.paddr & OFFSET_MASK;

			// Only the decoded port sees psel
			downstream_req[g].psel = upstream_req.psel && port_hit && (int'(devid) == g);
		end
	end

	////////////////////////////////////////
	// Reply mux

	always_comb begin
		// Idle bus returns all zero
		upstream_rsp = '0;

		// Access phase to a mapped block, pass its reply straight through
		if (upstream_req.penable && port_hit) begin
			upstream_rsp = downstream_rsp[devid];
		end

		// Nobody answers outside the window, so close the transfer here
		if (ERR_ON_INVALID && upstream_req.penable && !port_hit) begin
			upstream_rsp.pready  = 1'b1;
			upstream_rsp.pslverr = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/apb_scratch_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

// Word-addressed scratch RAM
// Writes finish in the first access cycle, reads take one wait state
module apb_scratch_ram #(
	parameter int RAM_WORDS = 64
) (
	input  wire               pclk,
	input  wire               rst_n,
	input  apb_pkg::apb_req_t req,
	output apb_pkg::apb_rsp_t rsp
);

	import apb_pkg::*;

	localparam int IDX_BITS = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

	// Size of the mapped region in bytes
	localparam logic [ADDR_WIDTH-1:0] RAM_BYTES = ADDR_WIDTH'(RAM_WORDS * STRB_WIDTH);

	////////////////////////////////////////
	// Decode

	logic                  access;
	logic                  in_range;
	logic [IDX_BITS-1:0]   word_idx;

	// Second phase of a transfer addressed to us
	assign access   = req.psel && req.penable;

	// Low two bits select a byte and are ignored
	assign word_idx = req.paddr[2 +: IDX_BITS];
	assign in_range = (req.paddr < RAM_BYTES);

	////////////////////////////////////////
	// Storage

	logic [DATA_WIDTH-1:0] mem [RAM_WORDS];
	logic [DATA_WIDTH-1:0] rd_data;

	// Set after the first read access cycle, cleared when the read completes
	logic                  rd_wait;

	always_ff @(posedge pclk) begin
		// Strobed write, only enabled bytes change
		if (access && req.pwrite && in_range) begin
			for (int b = 0; b < STRB_WIDTH; b++) begin
				if (req.pstrb[b])
					mem[word_idx][b*8 +: 8] <= req.pwdata[b*8 +: 8];
			end
		end

		// Read word registered in the first access cycle
		if (access && !req.pwrite && !rd_wait && in_range)
			rd_data <= mem[word_idx];
	end

	////////////////////////////////////////
	// Wait state

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			rd_wait <= 1'b0;
		end else if (access && !req.pwrite) begin
			// Toggles once per read: set in cycle 1, back to zero at completion
			rd_wait <= !rd_wait;
		end else begin
			rd_wait <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Response

	always_comb begin
		rsp = '0;

		// Writes never stall, reads wait for the data register
		rsp.pready  = access && (req.pwrite || rd_wait);

		// Out of range completes normally but flagged
		rsp.pslverr = rsp.pready && !in_range;

		// Registered word only shown on a good read
		if (rsp.pready && !req.pwrite && in_range)
			rsp.prdata = rd_data;
	end

endmodule

`default_nettype wire

// ==== src/apb_crc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

// CRC-32 accumulator
// DATA folds a word in, RESULT reads the checksum, INIT restarts it
module apb_crc_unit (
	input  wire               pclk,
	input  wire               rst_n,
	input  apb_pkg::apb_req_t req,
	output apb_pkg::apb_rsp_t rsp
);

	import apb_pkg::*;

	////////////////////////////////////////
	// CRC step

	// Bitwise reflected CRC over one word
	// LSB first, which matches a byte stream sent low byte first
	function automatic logic [31:0] crc_fold(
		input logic [31:0]           crc_in,
		input logic [DATA_WIDTH-1:0] data
	);
		logic [31:0] c;
		c = crc_in;
		for (int i = 0; i < DATA_WIDTH; i++) begin
			if (c[0] ^ data[i])
				c = (c >> 1) ^ CRC_POLY;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	////////////////////////////////////////
	// Register decode

	logic access;
	logic is_data;
	logic is_result;
	logic is_init;
	logic full_strb;

	// Only the legal access kinds get a clean completion
	logic wr_data_ok;
	logic wr_init_ok;
	logic rd_result_ok;
	logic access_ok;

	assign access    = req.psel && req.penable;

	assign is_data   = (req.paddr == CRC_REG_DATA);
	assign is_result = (req.paddr == CRC_REG_RESULT);
	assign is_init   = (req.paddr == CRC_REG_INIT);

	// Partial words would corrupt the checksum
	assign full_strb = &req.pstrb;

	assign wr_data_ok   = req.pwrite && is_data && full_strb;
	assign wr_init_ok   = req.pwrite && is_init;
	assign rd_result_ok = !req.pwrite && is_result;
	assign access_ok    = wr_data_ok || wr_init_ok || rd_result_ok;

	////////////////////////////////////////
	// Accumulator

	logic [31:0] crc_q;

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			crc_q <= CRC_INIT;
		end else if (access) begin
			// Errored accesses leave the running value alone
			if (wr_data_ok)
				crc_q <= crc_fold(crc_q, req.pwdata);
			else if (wr_init_ok)
				crc_q <= CRC_INIT;
		end
	end

	////////////////////////////////////////
	// Response

	always_comb begin
		rsp = '0;

		// Every access ends in its first access cycle
		rsp.pready  = access;
		rsp.pslverr = access && !access_ok;

		// Final inversion applied on readout only
		if (access && rd_result_ok)
			rsp.prdata = crc_q ^ CRC_XOROUT;
	end

endmodule

`default_nettype wire

// ==== src/apb_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

// APB peripheral subsystem
// Bridge port 0 is the scratch RAM, port 1 the CRC unit
module apb_subsystem #(
	parameter logic [apb_pkg::ADDR_WIDTH-1:0] BASE_ADDR      = 32'h4000_0000,
	parameter logic [apb_pkg::ADDR_WIDTH-1:0] BLOCK_SIZE     = 32'h0000_0800,
	parameter bit                             ERR_ON_INVALID = 1'b1,
	// Scratch RAM depth in words
	parameter int                             RAM_WORDS      = 64
) (
	input  wire               pclk,
	input  wire               rst_n,
	input  apb_pkg::apb_req_t upstream_req,
	output apb_pkg::apb_rsp_t upstream_rsp
);

	import apb_pkg::*;

	// One port per peripheral below
	localparam int NUM_PORTS = 2;

	////////////////////////////////////////
	// Per-peripheral channels

	apb_req_t dev_req [NUM_PORTS-1:0];
	apb_rsp_t dev_rsp [NUM_PORTS-1:0];

	////////////////////////////////////////
	// Address decode

	apb_bridge #(
		.BASE_ADDR      (BASE_ADDR),
		.BLOCK_SIZE     (BLOCK_SIZE),
		.NUM_PORTS      (NUM_PORTS),
		.ERR_ON_INVALID (ERR_ON_INVALID)
	) u_bridge (
		.upstream_req   (upstream_req),
		.upstream_rsp   (upstream_rsp),
		.downstream_req (dev_req),
		.downstream_rsp (dev_rsp)
	);

	////////////////////////////////////////
	// Peripherals

	// Block 0 at BASE_ADDR
	apb_scratch_ram #(
		.RAM_WORDS (RAM_WORDS)
	) u_ram (
		.pclk  (pclk),
		.rst_n (rst_n),
		.req   (dev_req[0]),
		.rsp   (dev_rsp[0])
	);

	// Block 1 at BASE_ADDR + BLOCK_SIZE
	apb_crc_unit u_crc (
		.pclk  (pclk),
		.rst_n (rst_n),
		.req   (dev_req[1]),
		.rsp   (dev_rsp[1])
	);

endmodule

`default_nettype wire

// ==== tb/apb_subsystem_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

// APB protocol checks around the address bridge
// Sampled on the subsystem clock and reset
module apb_subsystem_asserts #(
	parameter int NUM_PORTS = 2
) (
	input wire               pclk,
	input wire               rst_n,
	input apb_pkg::apb_req_t upstream_req,
	input apb_pkg::apb_rsp_t upstream_rsp,
	input apb_pkg::apb_req_t downstream_req [NUM_PORTS-1:0]
);

	// Collected select lines of all ports
	logic [NUM_PORTS-1:0] psel_vec;

	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++)
			psel_vec[i] = downstream_req[i].psel;
	end

	// Decoder picks one block at most
	psel_onehot: assert property (@(posedge pclk) disable iff (!rst_n)
		$onehot0(psel_vec))
		else $error("more than one downstream psel high");

	// Requester holds everything while the completer stalls
	req_stable: assert property (@(posedge pclk) disable iff (!rst_n)
		upstream_req.psel && upstream_req.penable && !upstream_rsp.pready |=>
		$stable(upstream_req))
		else $error("request changed during a wait state");

	// No completion outside the access phase
	ready_in_access: assert property (@(posedge pclk) disable iff (!rst_n)
		!upstream_req.penable |-> !upstream_rsp.pready)
		else $error("pready high without penable");

endmodule

bind apb_subsystem apb_subsystem_asserts #(
	.NUM_PORTS (NUM_PORTS)
) u_asserts (
	.pclk           (pclk),
	.rst_n          (rst_n),
	.upstream_req   (upstream_req),
	.upstream_rsp   (upstream_rsp),
	.downstream_req (dev_req)
);

`default_nettype wire

// ==== tb/tb_apb_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_apb_subsystem;

	import apb_pkg::*;

	localparam logic [31:0] BASE_ADDR  = 32'h4000_0000;
	localparam logic [31:0] BLOCK_SIZE = 32'h0000_0800;
	localparam int          RAM_WORDS  = 64;
	localparam logic [31:0] CRC_BASE   = BASE_ADDR + BLOCK_SIZE;

	// Test lengths
	// The timeout limit follows from the transfer count
	localparam int T1_WORDS  = 16;
	localparam int T2_WORDS  = 8;
	localparam int T3_WORDS  = 12;
	localparam int T5_ROUNDS = 6;
	localparam int NUM_TRANSFERS = 2 * T1_WORDS + 3 * T2_WORDS + (T3_WORDS + 4) + 9 +
		(3 * T5_ROUNDS + 2);
	localparam int TIMEOUT_CYCLES = 40 * NUM_TRANSFERS;

	logic     pclk = 1'b0;
	logic     rst_n;
	apb_req_t upstream_req;
	apb_rsp_t upstream_rsp;

	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;

	// Reference state
	logic [31:0] shadow [RAM_WORDS];
	logic [31:0] crc_words [$];

	always #5 pclk = ~pclk;

	apb_subsystem #(
		.BASE_ADDR      (BASE_ADDR),
		.BLOCK_SIZE     (BLOCK_SIZE),
		.ERR_ON_INVALID (1'b1),
		.RAM_WORDS      (RAM_WORDS)
	) u_apb_subsystem (
		.pclk         (pclk),
		.rst_n        (rst_n),
		.upstream_req (upstream_req),
		.upstream_rsp (upstream_rsp)
	);

	////////////////////////////////////////
	// Reference models

	function automatic logic [31:0] ram_addr(input int idx);
		return BASE_ADDR + 32'(idx) * 32'd4;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] strb);
		logic [31:0] w;
		w = old_word;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				w[b*8 +: 8] = new_word[b*8 +: 8];
		end
		return w;
	endfunction

	// One byte at a time with the low byte of each word first
	function automatic logic [31:0] crc32_ref(input logic [31:0] words [$]);
		logic [31:0] crc;
		logic [7:0]  byte_val;
		crc = CRC_INIT;
		foreach (words[w]) begin
			for (int b = 0; b < 4; b++) begin
				byte_val = words[w][b*8 +: 8];
				crc = crc ^ {24'h0, byte_val};
				for (int k = 0; k < 8; k++)
					crc = crc[0] ? ((crc >> 1) ^ CRC_POLY) : (crc >> 1);
			end
		end
		return crc ^ CRC_XOROUT;
	endfunction

	// Address map with the RAM in block 0 and the CRC unit in block 1
	function automatic bit access_valid(input bit write, input logic [31:0] addr,
		input logic [3:0] strb);
		logic [31:0] rel;
		logic [31:0] off;
		if (addr < BASE_ADDR || addr >= BASE_ADDR + 2 * BLOCK_SIZE)
			return 1'b0;
		rel = addr - BASE_ADDR;
		off = rel % BLOCK_SIZE;
		if (rel < BLOCK_SIZE)
			return off < RAM_WORDS * 4;
		return (write && off == CRC_REG_DATA && strb == 4'hF) ||
			(write && off == CRC_REG_INIT) || (!write && off == CRC_REG_RESULT);
	endfunction

	////////////////////////////////////////
	// Compare tasks

	task automatic check_data(input apb_rsp_t rsp, input logic [DATA_WIDTH-1:0] exp,
		input string what);
		if (rsp.pslverr !== 1'b0 || rsp.prdata !== exp) begin
			$display("Fail at %0t: %s read 0x%08h err %0b, expected 0x%08h",
				$time, what, rsp.prdata, rsp.pslverr, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_error(input apb_rsp_t rsp, input string what);
		if (rsp.pslverr !== 1'b1) begin
			$display("Fail at %0t: %s expected an error response", $time, what);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_ack(input apb_rsp_t rsp, input string what);
		if (rsp.pslverr !== 1'b0) begin
			$display("Fail at %0t: %s got an unexpected error", $time, what);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	////////////////////////////////////////
	// APB driver

	// Setup on one edge and access on the next, held until pready
	task automatic apb_transfer(input bit write, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] strb, output apb_rsp_t rsp);
		apb_req_t req;
		req = '0;
		req.psel   = 1'b1;
		req.pwrite = write;
		req.paddr  = addr;
		req.pwdata = data;
		req.pstrb  = strb;
		@(posedge pclk);
		upstream_req <= req;
		@(posedge pclk);
		upstream_req.penable <= 1'b1;
		// Response sampled mid-cycle
		do
			@(negedge pclk);
		while (upstream_rsp.pready !== 1'b1);
		rsp = upstream_rsp;
	endtask

	task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input string what);
		apb_rsp_t rsp;
		apb_transfer(1'b1, addr, data, strb, rsp);
		if (access_valid(1'b1, addr, strb))
			check_ack(rsp, what);
		else
			check_error(rsp, what);
	endtask

	task automatic apb_read(input logic [31:0] addr, input logic [31:0] exp,
		input string what);
		apb_rsp_t rsp;
		apb_transfer(1'b0, addr, '0, 4'h0, rsp);
		if (access_valid(1'b0, addr, 4'h0))
			check_data(rsp, exp, what);
		else
			check_error(rsp, what);
	endtask

	task automatic report_test(input string name, input int base);
		if (fail_count == base)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d failed checks", name, fail_count - base);
	endtask

	////////////////////////////////////////
	// Timeout

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge pclk);
			cycle_count++;
		end
		$display("Run timed out after %0d cycles", cycle_count);
		$display("TESTBENCH FAILED");
		$finish;
	end

	////////////////////////////////////////
	// Test sequence

	initial begin
		int          idx;
		int          j;
		int          base;
		int          order [$];
		logic [31:0] wdata;
		logic [3:0]  strb;

		void'($urandom(67));
		upstream_req = '0;
		rst_n = 1'b0;
		repeat (5) @(posedge pclk);
		rst_n <= 1'b1;

		// Full words read back in shuffled order
		base = fail_count;
		for (int i = 0; i < T1_WORDS; i++) begin
			idx = int'($urandom_range(RAM_WORDS - 1));
			wdata = $urandom;
			apb_write(ram_addr(idx), wdata, 4'hF, "ram word write");
			shadow[idx] = wdata;
			order.push_back(idx);
		end
		for (int i = order.size() - 1; i > 0; i--) begin
			j = int'($urandom_range(i));
			idx = order[i];
			order[i] = order[j];
			order[j] = idx;
		end
		foreach (order[i])
			apb_read(ram_addr(order[i]), shadow[order[i]], "ram word read");
		report_test("ram full-word writes", base);

		// Partial strobes on top of a known word
		base = fail_count;
		for (int i = 0; i < T2_WORDS; i++) begin
			idx = int'($urandom_range(RAM_WORDS - 1));
			wdata = $urandom;
			apb_write(ram_addr(idx), wdata, 4'hF, "ram base write");
			shadow[idx] = wdata;
			wdata = $urandom;
			strb = 4'($urandom_range(14, 1));
			apb_write(ram_addr(idx), wdata, strb, "ram strobe write");
			shadow[idx] = merge_bytes(shadow[idx], wdata, strb);
			apb_read(ram_addr(idx), shadow[idx], "ram merged read");
		end
		report_test("ram byte strobes", base);

		// CRC over random words and then back to empty
		base = fail_count;
		apb_write(CRC_BASE + CRC_REG_INIT, '0, 4'hF, "crc init");
		crc_words.delete();
		for (int i = 0; i < T3_WORDS; i++) begin
			wdata = $urandom;
			apb_write(CRC_BASE + CRC_REG_DATA, wdata, 4'hF, "crc data write");
			crc_words.push_back(wdata);
		end
		apb_read(CRC_BASE + CRC_REG_RESULT, crc32_ref(crc_words), "crc result");
		apb_write(CRC_BASE + CRC_REG_INIT, '0, 4'hF, "crc reinit");
		crc_words.delete();
		apb_read(CRC_BASE + CRC_REG_RESULT, crc32_ref(crc_words), "crc empty result");
		report_test("crc accumulate", base);

		// Error cases
		// The accumulator must survive the partial data write
		base = fail_count;
		apb_write(CRC_BASE + CRC_REG_INIT, '0, 4'hF, "crc init");
		wdata = $urandom;
		apb_write(CRC_BASE + CRC_REG_DATA, wdata, 4'hF, "crc data write");
		crc_words.push_back(wdata);
		apb_write(CRC_BASE + CRC_REG_DATA, $urandom, 4'h3, "crc partial data write");
		apb_read(CRC_BASE + CRC_REG_RESULT, crc32_ref(crc_words), "crc result after error");
		apb_read(CRC_BASE + CRC_REG_DATA, '0, "crc data read");
		apb_read(ram_addr(RAM_WORDS), '0, "ram read past end");
		apb_write(ram_addr(RAM_WORDS + 1), $urandom, 4'hF, "ram write past end");
		apb_read(BASE_ADDR + 2 * BLOCK_SIZE, '0, "read above window");
		apb_write(BASE_ADDR - 4, $urandom, 4'hF, "write below window");
		report_test("error responses", base);

		// RAM read straight into a CRC write
		base = fail_count;
		apb_write(CRC_BASE + CRC_REG_INIT, '0, 4'hF, "crc init");
		crc_words.delete();
		for (int i = 0; i < T5_ROUNDS; i++) begin
			idx = int'($urandom_range(RAM_WORDS - 1));
			wdata = $urandom;
			apb_write(ram_addr(idx), wdata, 4'hF, "interleaved ram write");
			shadow[idx] = wdata;
			apb_read(ram_addr(idx), shadow[idx], "interleaved ram read");
			wdata = $urandom;
			apb_write(CRC_BASE + CRC_REG_DATA, wdata, 4'hF, "interleaved crc write");
			crc_words.push_back(wdata);
		end
		apb_read(CRC_BASE + CRC_REG_RESULT, crc32_ref(crc_words), "interleaved crc result");
		report_test("interleaved blocks", base);

		// Bus back to idle
		@(posedge pclk);
		upstream_req <= '0;
		@(posedge pclk);

		$display("Checks: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/apb_pkg.sv
src/apb_bridge.sv
src/apb_scratch_ram.sv
src/apb_crc_unit.sv
src/apb_subsystem.sv
tb/apb_subsystem_asserts.sv
tb/tb_apb_subsystem.sv

// ==== Makefile ====
# Verilator build and run of the APB subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_apb_subsystem
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
